/* include/mm_defs.svh */
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// vector shape
`define MM_LANES 4
`define MM_DATA_W 32

// buffer address widths
`define MM_FEAT_ADDR_W 11
`define MM_WEIGHT_ADDR_W 13
`define MM_BIAS_ADDR_W 9

// job count widths
`define MM_CNT_W 8
`define MM_NODE_W 16

// fixed pipeline latencies in cycles
`define MM_RD_LAT 1
`define MM_MUL_LAT 2

`endif

/* src/mm_pkg.sv */
`include "mm_defs.svh"

package mm_pkg;

    //////////////////////////////////////////////////////////////////////
    // data words
    //////////////////////////////////////////////////////////////////////

    typedef logic [`MM_DATA_W-1:0] lane_t;

    // one input, output or bias buffer word
    typedef lane_t [`MM_LANES-1:0] vec_t;

    // one weight word whose row j feeds output lane j
    typedef vec_t [`MM_LANES-1:0] blk_t;

    //////////////////////////////////////////////////////////////////////
    // job and control
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`MM_WEIGHT_ADDR_W-1:0] weight_start;
        logic [`MM_FEAT_ADDR_W-1:0]   input_start;
        logic [`MM_FEAT_ADDR_W-1:0]   output_start;
        logic [`MM_BIAS_ADDR_W-1:0]   bias_start;
        logic [`MM_CNT_W-1:0]         ci_count;
        logic [`MM_CNT_W-1:0]         co_count;
        logic [`MM_NODE_W-1:0]        node_count;
        logic                         bias_en;
        logic                         relu_en;
    } mm_cfg_t;

    // travels with every read through the datapath
    typedef struct packed {
        logic valid;
        logic first_ci;
        logic last_ci;
        // last block of the job
        logic final_blk;
    } mm_tag_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_e;

endpackage

/* src/mm_loop_ctrl.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"

module mm_loop_ctrl (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         start,
    input  mm_pkg::mm_cfg_t              cfg,
    output logic [`MM_FEAT_ADDR_W-1:0]   input_addr,
    output logic                         input_addr_valid,
    output logic [`MM_WEIGHT_ADDR_W-1:0] weight_addr,
    output logic                         weight_addr_valid,
    output logic [`MM_BIAS_ADDR_W-1:0]   bias_addr,
    output logic                         bias_addr_valid,
    output mm_pkg::mm_cfg_t              job,
    output mm_pkg::mm_tag_t              rd_tag,
    output logic                         busy
);
    import mm_pkg::*;

    // last read -> result -> done takes this many cycles
    localparam int DRAIN_CYC = `MM_RD_LAT + `MM_MUL_LAT + 1;
    localparam int DRAIN_W   = $clog2(DRAIN_CYC);

    ctrl_state_e                  state;
    logic [DRAIN_W-1:0]           drain_cnt;

    logic [`MM_CNT_W-1:0]         ci;
    logic [`MM_CNT_W-1:0]         co;
    logic [`MM_NODE_W-1:0]        n;
    logic                         ci_last;
    logic                         co_last;
    logic                         n_last;

    // next address to issue
    logic [`MM_FEAT_ADDR_W-1:0]   in_ptr;
    logic [`MM_WEIGHT_ADDR_W-1:0] w_ptr;
    logic [`MM_BIAS_ADDR_W-1:0]   b_ptr;

    logic                         issue;
    logic                         job_load;
    mm_tag_t                      issue_tag;
    mm_tag_t                      tag_q;
    mm_tag_t                      tag_pipe [`MM_RD_LAT];

    assign job_load = (state == IDLE) && start;

    // stop issuing once the final triple is on the address bus
    assign issue = (state == RUN) && !tag_q.final_blk;

    assign ci_last = (ci == job.ci_count - `MM_CNT_W'(1));
    assign co_last = (co == job.co_count - `MM_CNT_W'(1));
    assign n_last  = (n == job.node_count - `MM_NODE_W'(1));

    always_comb begin
        issue_tag.valid     = 1'b1;
        issue_tag.first_ci  = (ci == '0);
        issue_tag.last_ci   = ci_last;
        issue_tag.final_blk = ci_last && co_last && n_last;
    end

    assign busy = (state != IDLE);

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (tag_q.final_blk) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == DRAIN_W'(DRAIN_CYC - 1)) begin
                        state <= IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // loop counters with ci innermost
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ci <= '0;
            co <= '0;
            n  <= '0;
        end else if (job_load) begin
            ci <= '0;
            co <= '0;
            n  <= '0;
        end else if (issue) begin
            if (!ci_last) begin
                ci <= ci + 1'b1;
            end else begin
                ci <= '0;
                if (!co_last) begin
                    co <= co + 1'b1;
                end else begin
                    co <= '0;
                    n  <= n + 1'b1;
                end
            end
        end
    end

    // job latch and address walk
    always_ff @(posedge clk) begin
        if (job_load) begin
            job    <= cfg;
            in_ptr <= cfg.input_start;
            w_ptr  <= cfg.weight_start;
            b_ptr  <= cfg.bias_start;
        end else if (issue) begin
            if (!ci_last) begin
                in_ptr <= in_ptr + 1'b1;
                w_ptr  <= w_ptr + 1'b1;
            end else if (!co_last) begin
                // same node again for the next output block
                in_ptr <= in_ptr - `MM_FEAT_ADDR_W'(job.ci_count) + 1'b1;
                w_ptr  <= w_ptr + 1'b1;
                b_ptr  <= b_ptr + 1'b1;
            end else begin
                in_ptr <= in_ptr + 1'b1;
                w_ptr  <= job.weight_start;
                b_ptr  <= job.bias_start;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read issue and tag alignment
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            input_addr_valid  <= 1'b0;
            weight_addr_valid <= 1'b0;
            bias_addr_valid   <= 1'b0;
            tag_q             <= '0;
        end else begin
            input_addr_valid  <= issue;
            weight_addr_valid <= issue;
            bias_addr_valid   <= issue && job.bias_en && ci_last;
            tag_q             <= issue ? issue_tag : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            input_addr  <= in_ptr;
            weight_addr <= w_ptr;
            bias_addr   <= b_ptr;
        end
    end

    // tag catches up with the returning buffer data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `MM_RD_LAT; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= tag_q;
            for (int i = 1; i < `MM_RD_LAT; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign rd_tag = tag_pipe[`MM_RD_LAT-1];

    a_addr_in_run: assert property (@(posedge clk) disable iff (!rstn)
        (input_addr_valid || weight_addr_valid || bias_addr_valid) |-> (state == RUN));

endmodule

/* src/mm_dot_array.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"

module mm_dot_array (
    input  logic            clk,
    input  logic            rstn,
    input  mm_pkg::vec_t    vec_in,
    input  mm_pkg::blk_t    blk_in,
    input  mm_pkg::mm_tag_t tag_in,
    output mm_pkg::vec_t    prod,
    output mm_pkg::mm_tag_t prod_tag
);
    import mm_pkg::*;

    // lane products indexed [row][input lane]
    lane_t   mul_q [`MM_LANES][`MM_LANES];
    vec_t    row_sum;
    mm_tag_t tag_q;

    //////////////////////////////////////////////////////////////////////
    // stage 1 multiply
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int j = 0; j < `MM_LANES; j++) begin
            for (int i = 0; i < `MM_LANES; i++) begin
                // low 32 bits only
                mul_q[j][i] <= blk_in[j][i] * vec_in[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2 row reduce
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < `MM_LANES; j++) begin
            row_sum[j] = '0;
            for (int i = 0; i < `MM_LANES; i++) begin
                row_sum[j] = row_sum[j] + mul_q[j][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        prod <= row_sum;
    end

    // tag rides along with one register per stage
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag_q    <= '0;
            prod_tag <= '0;
        end else begin
            tag_q    <= tag_in;
            prod_tag <= tag_q;
        end
    end

    a_tag_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(tag_in.valid));

endmodule

/* src/mm_accumulate.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"

module mm_accumulate (
    input  logic                       clk,
    input  logic                       rstn,
    input  mm_pkg::vec_t               prod,
    input  mm_pkg::mm_tag_t            prod_tag,
    input  mm_pkg::vec_t               bias_data,
    input  mm_pkg::mm_cfg_t            job,
    input  logic                       busy,
    output mm_pkg::vec_t               output_data,
    output logic [`MM_FEAT_ADDR_W-1:0] output_addr,
    output logic                       output_data_valid,
    output logic                       done
);
    import mm_pkg::*;

    vec_t bias_pipe [`MM_MUL_LAT];
    vec_t acc_q;
    vec_t acc_sum;
    vec_t blk_sum;
    vec_t relu_out;
    logic blk_done;
    logic first_out;
    logic final_q;

    assign blk_done = prod_tag.valid && prod_tag.last_ci;

    //////////////////////////////////////////////////////////////////////
    // bias alignment
    //////////////////////////////////////////////////////////////////////

    // bias word arrives with rd_tag and the product MM_MUL_LAT later
    always_ff @(posedge clk) begin
        bias_pipe[0] <= bias_data;
        for (int i = 1; i < `MM_MUL_LAT; i++) begin
            bias_pipe[i] <= bias_pipe[i-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accumulate, bias, relu
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `MM_LANES; i++) begin
            // first ci restarts the sum
            acc_sum[i] = prod_tag.first_ci ? prod[i] : acc_q[i] + prod[i];
            blk_sum[i] = acc_sum[i];
            if (job.bias_en) begin
                blk_sum[i] = acc_sum[i] + bias_pipe[`MM_MUL_LAT-1][i];
            end
            relu_out[i] = blk_sum[i];
            if (job.relu_en && blk_sum[i][`MM_DATA_W-1]) begin
                relu_out[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_tag.valid) begin
            acc_q <= acc_sum;
        end
        if (blk_done) begin
            output_data <= relu_out;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output addressing and done
    //////////////////////////////////////////////////////////////////////

    // first result of a job goes to output_start
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            first_out <= 1'b1;
        end else if (!busy) begin
            first_out <= 1'b1;
        end else if (blk_done) begin
            first_out <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_done) begin
            output_addr <= first_out ? job.output_start : output_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            output_data_valid <= 1'b0;
            final_q           <= 1'b0;
            done              <= 1'b0;
        end else begin
            output_data_valid <= blk_done;
            final_q           <= prod_tag.valid && prod_tag.final_blk;
            // one cycle behind the final output
            done              <= final_q;
        end
    end

    a_valid_done_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(output_data_valid && done));

    // controller still in DRAIN when done is raised
    a_done_in_job: assert property (@(posedge clk) disable iff (!rstn)
        done |-> $past(busy));

endmodule

/* src/mm_engine.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"

module mm_engine (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         start,

    // job description sampled with start
    input  logic [`MM_WEIGHT_ADDR_W-1:0] weight_start_addr,
    input  logic [`MM_FEAT_ADDR_W-1:0]   input_start_addr,
    input  logic [`MM_FEAT_ADDR_W-1:0]   output_start_addr,
    input  logic [`MM_BIAS_ADDR_W-1:0]   bias_start_addr,
    input  logic [`MM_CNT_W-1:0]         ci_count,
    input  logic [`MM_CNT_W-1:0]         co_count,
    input  logic [`MM_NODE_W-1:0]        node_count,
    input  logic                         bias_en,
    input  logic                         relu_en,

    // buffer read data one cycle after the address
    input  mm_pkg::vec_t                 input_data,
    input  mm_pkg::blk_t                 weight_data,
    input  mm_pkg::vec_t                 bias_data,

    output logic [`MM_FEAT_ADDR_W-1:0]   input_addr,
    output logic                         input_addr_valid,
    output logic [`MM_WEIGHT_ADDR_W-1:0] weight_addr,
    output logic                         weight_addr_valid,
    output logic [`MM_BIAS_ADDR_W-1:0]   bias_addr,
    output logic                         bias_addr_valid,

    output mm_pkg::vec_t                 output_data,
    output logic [`MM_FEAT_ADDR_W-1:0]   output_addr,
    output logic                         output_data_valid,
    output logic                         done
);
    import mm_pkg::*;

    mm_cfg_t cfg;
    mm_cfg_t job;
    mm_tag_t rd_tag;
    mm_tag_t prod_tag;
    vec_t    prod;
    logic    busy;

    assign cfg = '{
        weight_start: weight_start_addr,
        input_start:  input_start_addr,
        output_start: output_start_addr,
        bias_start:   bias_start_addr,
        ci_count:     ci_count,
        co_count:     co_count,
        node_count:   node_count,
        bias_en:      bias_en,
        relu_en:      relu_en
    };

    mm_loop_ctrl u_loop_ctrl (
        .clk               (clk),
        .rstn              (rstn),
        .start             (start),
        .cfg               (cfg),
        .input_addr        (input_addr),
        .input_addr_valid  (input_addr_valid),
        .weight_addr       (weight_addr),
        .weight_addr_valid (weight_addr_valid),
        .bias_addr         (bias_addr),
        .bias_addr_valid   (bias_addr_valid),
        .job               (job),
        .rd_tag            (rd_tag),
        .busy              (busy)
    );

    mm_dot_array u_dot_array (
        .clk      (clk),
        .rstn     (rstn),
        .vec_in   (input_data),
        .blk_in   (weight_data),
        .tag_in   (rd_tag),
        .prod     (prod),
        .prod_tag (prod_tag)
    );

    mm_accumulate u_accumulate (
        .clk               (clk),
        .rstn              (rstn),
        .prod              (prod),
        .prod_tag          (prod_tag),
        .bias_data         (bias_data),
        .job               (job),
        .busy              (busy),
        .output_data       (output_data),
        .output_addr       (output_addr),
        .output_data_valid (output_data_valid),
        .done              (done)
    );

endmodule

/* dv/tb_mm_engine.sv */
`timescale 1ns/1ps
`include "mm_defs.svh"

module tb_mm_engine;
    import mm_pkg::*;

    localparam int IN_DEPTH = 1 << `MM_FEAT_ADDR_W;
    localparam int W_DEPTH  = 1 << `MM_WEIGHT_ADDR_W;
    localparam int B_DEPTH  = 1 << `MM_BIAS_ADDR_W;
    // N*Co*Ci + 20 per job over six jobs
    localparam int WATCHDOG_CYC = 21 + 25 + 26 + 38 + 28 + 26;

    logic    clk;
    logic    rstn;
    logic    start;
    mm_cfg_t cfg;
    vec_t    input_data;
    blk_t    weight_data;
    vec_t    bias_data;

    logic [`MM_FEAT_ADDR_W-1:0]   input_addr;
    logic                         input_addr_valid;
    logic [`MM_WEIGHT_ADDR_W-1:0] weight_addr;
    logic                         weight_addr_valid;
    logic [`MM_BIAS_ADDR_W-1:0]   bias_addr;
    logic                         bias_addr_valid;
    vec_t                         output_data;
    logic [`MM_FEAT_ADDR_W-1:0]   output_addr;
    logic                         output_data_valid;
    logic                         done;

    // buffer models
    vec_t in_mem [IN_DEPTH];
    blk_t w_mem [W_DEPTH];
    vec_t b_mem [B_DEPTH];
    logic [`MM_FEAT_ADDR_W-1:0]   in_rd_addr;
    logic [`MM_WEIGHT_ADDR_W-1:0] w_rd_addr;
    logic [`MM_BIAS_ADDR_W-1:0]   b_rd_addr;

    // expected traffic with offsets in cycles from the start edge
    logic [`MM_FEAT_ADDR_W-1:0]   exp_in_addr [$];
    logic [`MM_WEIGHT_ADDR_W-1:0] exp_w_addr [$];
    int                           exp_rd_off [$];
    logic [`MM_BIAS_ADDR_W-1:0]   exp_b_addr [$];
    int                           exp_b_off [$];
    logic [`MM_FEAT_ADDR_W-1:0]   exp_out_addr [$];
    vec_t                         exp_out_data [$];
    int                           exp_out_off [$];
    int                           exp_done_off;
    bit                           done_pending;

    int          cyc;
    int          base_cyc;
    int          err_count;
    int          check_count;
    int          tests_run;
    int          tests_passed;
    int          relu_zeroed;
    logic [31:0] rng;

    mm_engine UUT (
        .clk               (clk),
        .rstn              (rstn),
        .start             (start),
        .weight_start_addr (cfg.weight_start),
        .input_start_addr  (cfg.input_start),
        .output_start_addr (cfg.output_start),
        .bias_start_addr   (cfg.bias_start),
        .ci_count          (cfg.ci_count),
        .co_count          (cfg.co_count),
        .node_count        (cfg.node_count),
        .bias_en           (cfg.bias_en),
        .relu_en           (cfg.relu_en),
        .input_data        (input_data),
        .weight_data       (weight_data),
        .bias_data         (bias_data),
        .input_addr        (input_addr),
        .input_addr_valid  (input_addr_valid),
        .weight_addr       (weight_addr),
        .weight_addr_valid (weight_addr_valid),
        .bias_addr         (bias_addr),
        .bias_addr_valid   (bias_addr_valid),
        .output_data       (output_data),
        .output_addr       (output_addr),
        .output_data_valid (output_data_valid),
        .done              (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // address on the rising edge and data on the next falling edge
    always @(posedge clk) begin
        if (input_addr_valid) begin
            in_rd_addr <= input_addr;
        end
        if (weight_addr_valid) begin
            w_rd_addr <= weight_addr;
        end
        if (bias_addr_valid) begin
            b_rd_addr <= bias_addr;
        end
    end

    always @(negedge clk) begin
        input_data  <= in_mem[in_rd_addr];
        weight_data <= w_mem[w_rd_addr];
        bias_data   <= b_mem[b_rd_addr];
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic fill_memories();
        for (int a = 0; a < IN_DEPTH; a++) begin
            for (int l = 0; l < `MM_LANES; l++) begin
                in_mem[a][l] = next_rand();
            end
        end
        for (int a = 0; a < W_DEPTH; a++) begin
            for (int r = 0; r < `MM_LANES; r++) begin
                for (int l = 0; l < `MM_LANES; l++) begin
                    w_mem[a][r][l] = next_rand();
                end
            end
        end
        for (int a = 0; a < B_DEPTH; a++) begin
            for (int l = 0; l < `MM_LANES; l++) begin
                b_mem[a][l] = next_rand();
            end
        end
    endtask

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    function automatic mm_cfg_t make_cfg(
        input logic [`MM_WEIGHT_ADDR_W-1:0] w_start,
        input logic [`MM_FEAT_ADDR_W-1:0]   in_start,
        input logic [`MM_FEAT_ADDR_W-1:0]   out_start,
        input logic [`MM_BIAS_ADDR_W-1:0]   b_start,
        input int                           ci_n,
        input int                           co_n,
        input int                           node_n,
        input logic                         use_bias,
        input logic                         use_relu
    );
        mm_cfg_t c;
        c.weight_start = w_start;
        c.input_start  = in_start;
        c.output_start = out_start;
        c.bias_start   = b_start;
        c.ci_count     = `MM_CNT_W'(ci_n);
        c.co_count     = `MM_CNT_W'(co_n);
        c.node_count   = `MM_NODE_W'(node_n);
        c.bias_en      = use_bias;
        c.relu_en      = use_relu;
        return c;
    endfunction

    // sum over ci of W x X plus optional bias before relu
    function automatic vec_t ref_block(input mm_cfg_t c, input int n, input int co);
        vec_t acc;
        vec_t x;
        blk_t w;
        int   ci_n;
        ci_n = int'(c.ci_count);
        acc  = '0;
        for (int ci = 0; ci < ci_n; ci++) begin
            x = in_mem[int'(c.input_start) + n * ci_n + ci];
            w = w_mem[int'(c.weight_start) + co * ci_n + ci];
            for (int j = 0; j < `MM_LANES; j++) begin
                for (int i = 0; i < `MM_LANES; i++) begin
                    acc[j] = acc[j] + w[j][i] * x[i];
                end
            end
        end
        if (c.bias_en) begin
            for (int j = 0; j < `MM_LANES; j++) begin
                acc[j] = acc[j] + b_mem[int'(c.bias_start) + co][j];
            end
        end
        return acc;
    endfunction

    // queue every read, bias read and result the job should produce
    task automatic queue_expectations(input mm_cfg_t c);
        vec_t v;
        int   k;
        int   ci_n;
        int   co_n;
        ci_n = int'(c.ci_count);
        co_n = int'(c.co_count);
        k    = 0;
        for (int n = 0; n < int'(c.node_count); n++) begin
            for (int co = 0; co < co_n; co++) begin
                for (int ci = 0; ci < ci_n; ci++) begin
                    k++;
                    exp_in_addr.push_back(`MM_FEAT_ADDR_W'(int'(c.input_start) + n * ci_n + ci));
                    exp_w_addr.push_back(`MM_WEIGHT_ADDR_W'(int'(c.weight_start) + co * ci_n + ci));
                    exp_rd_off.push_back(k);
                end
                if (c.bias_en) begin
                    exp_b_addr.push_back(`MM_BIAS_ADDR_W'(int'(c.bias_start) + co));
                    exp_b_off.push_back(k);
                end
                v = ref_block(c, n, co);
                for (int j = 0; j < `MM_LANES; j++) begin
                    if (c.relu_en && v[j][`MM_DATA_W-1]) begin
                        v[j] = '0;
                        relu_zeroed++;
                    end
                end
                exp_out_addr.push_back(`MM_FEAT_ADDR_W'(int'(c.output_start) + n * co_n + co));
                exp_out_data.push_back(v);
                exp_out_off.push_back(k + `MM_RD_LAT + `MM_MUL_LAT + 1);
            end
        end
        exp_done_off = k + `MM_RD_LAT + `MM_MUL_LAT + 2;
        done_pending = 1'b1;
    endtask

    // stray adds a second start pulse a few cycles into the job
    task automatic run_job(input mm_cfg_t c, input bit stray);
        mm_cfg_t other;
        queue_expectations(c);
        @(negedge clk);
        cfg      = c;
        start    = 1'b1;
        base_cyc = cyc + 1;
        @(negedge clk);
        start = 1'b0;
        if (stray) begin
            repeat (2) @(negedge clk);
            other              = c;
            other.output_start = c.output_start + `MM_FEAT_ADDR_W'(100);
            other.co_count     = `MM_CNT_W'(1);
            cfg                = other;
            start              = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        while (!done) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        check("reads still pending", 128'(exp_in_addr.size()), 128'(0));
        check("bias reads still pending", 128'(exp_b_addr.size()), 128'(0));
        check("outputs still pending", 128'(exp_out_addr.size()), 128'(0));
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rstn) begin
            if (input_addr_valid || weight_addr_valid) begin
                if (exp_in_addr.size() == 0) begin
                    $display("Buffer read issued at %0t ns when no read was due", $time);
                    err_count++;
                end else begin
                    check("input_addr_valid", 128'(input_addr_valid), 128'(1));
                    check("weight_addr_valid", 128'(weight_addr_valid), 128'(1));
                    check("input_addr", 128'(input_addr), 128'(exp_in_addr.pop_front()));
                    check("weight_addr", 128'(weight_addr), 128'(exp_w_addr.pop_front()));
                    check("read cycle", 128'(cyc - base_cyc), 128'(exp_rd_off.pop_front()));
                end
            end
            if (bias_addr_valid) begin
                if (exp_b_addr.size() == 0) begin
                    $display("Bias read issued at %0t ns when no bias read was due", $time);
                    err_count++;
                end else begin
                    check("bias_addr", 128'(bias_addr), 128'(exp_b_addr.pop_front()));
                    check("bias read cycle", 128'(cyc - base_cyc), 128'(exp_b_off.pop_front()));
                end
            end
            if (output_data_valid) begin
                if (exp_out_addr.size() == 0) begin
                    $display("Output written at %0t ns when no result was due", $time);
                    err_count++;
                end else begin
                    check("output_addr", 128'(output_addr), 128'(exp_out_addr.pop_front()));
                    check("output_data", 128'(output_data), 128'(exp_out_data.pop_front()));
                    check("output cycle", 128'(cyc - base_cyc), 128'(exp_out_off.pop_front()));
                end
            end
            if (done) begin
                if (!done_pending) begin
                    $display("done pulsed at %0t ns with no job running", $time);
                    err_count++;
                end else begin
                    check("done cycle", 128'(cyc - base_cyc), 128'(exp_done_off));
                    done_pending = 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_single_block();
        int errs;
        errs = err_count;
        check("valids and done after reset",
              128'({input_addr_valid, weight_addr_valid, bias_addr_valid,
                    output_data_valid, done}), 128'(0));
        run_job(make_cfg(13'd40, 11'd7, 11'd300, 9'd0, 1, 1, 1, 1'b0, 1'b0), 1'b0);
        report_test("test 1 single block", errs);
    endtask

    task automatic test_accumulate();
        int errs;
        errs = err_count;
        run_job(make_cfg(13'd100, 11'd20, 11'd400, 9'd0, 5, 1, 1, 1'b0, 1'b0), 1'b0);
        report_test("test 2 accumulation over ci", errs);
    endtask

    task automatic test_bias_relu();
        int errs;
        errs        = err_count;
        relu_zeroed = 0;
        run_job(make_cfg(13'd200, 11'd50, 11'd500, 9'd30, 2, 3, 1, 1'b1, 1'b1), 1'b0);
        // random data should drive some lanes negative
        check("some lanes clipped by relu", 128'(relu_zeroed != 0), 128'(1));
        report_test("test 3 bias and relu", errs);
    endtask

    task automatic test_address_order();
        int errs;
        errs = err_count;
        run_job(make_cfg(13'd1000, 11'd600, 11'd900, 9'd0, 3, 2, 3, 1'b0, 1'b0), 1'b0);
        report_test("test 4 address order", errs);
    endtask

    task automatic test_back_to_back();
        int errs;
        errs = err_count;
        run_job(make_cfg(13'd2000, 11'd1000, 11'd1200, 9'd100, 2, 2, 2, 1'b1, 1'b0), 1'b1);
        run_job(make_cfg(13'd3000, 11'd1300, 11'd1500, 9'd0, 3, 2, 1, 1'b0, 1'b1), 1'b0);
        report_test("test 5 back-to-back jobs", errs);
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        start        = 1'b0;
        cfg          = '0;
        input_data   = '0;
        weight_data  = '0;
        bias_data    = '0;
        in_rd_addr   = '0;
        w_rd_addr    = '0;
        b_rd_addr    = '0;
        cyc          = 0;
        base_cyc     = 0;
        err_count    = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_passed = 0;
        relu_zeroed  = 0;
        done_pending = 1'b0;
        exp_done_off = 0;
        rng          = 32'hf6c95fe9;
        fill_memories();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        test_single_block();
        test_accumulate();
        test_bias_relu();
        test_address_order();
        test_back_to_back();

        $display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
                 tests_passed, tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYC * 20);
        $display("Watchdog expired: the tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Test failures found");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
src/mm_pkg.sv
src/mm_loop_ctrl.sv
src/mm_dot_array.sv
src/mm_accumulate.sv
src/mm_engine.sv
dv/tb_mm_engine.sv

/* run.sh */
#!/bin/sh
# build and run the mm_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mm_engine -f verilog.f -o sim_mm_engine
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_mm_engine)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
